// ==== bench/periph_assert.sv ====
`timescale 1ns/100ps

module periph_assert (
    input logic clk,
    input logic reset,
    input logic psel,
    input logic penable,
    input logic pready,
    input logic pslverr,
    input logic irq
);

    // completion only in the access phase right after its setup
    a_ready_in_access: assert property (@(posedge clk) disable iff (!reset)
        pready |-> psel && penable && $past(psel && !penable))
    else $error("pready outside an access phase");

    a_err_with_ready: assert property (@(posedge clk) disable iff (!reset)
        pslverr |-> pready)
    else $error("pslverr without pready");

    // sticky flag starts cleared
    a_irq_after_reset: assert property (@(posedge clk) $rose(reset) |-> !irq)
    else $error("irq high in the first cycle after reset");

endmodule

bind periph_top periph_assert u_assert (
    .clk     (clk),
    .reset   (reset),
    .psel    (psel),
    .penable (penable),
    .pready  (pready),
    .pslverr (pslverr),
    .irq     (irq)
);

// ==== bench/periph_tb.sv ====
`timescale 1ns/100ps

module periph_tb;

    localparam int CLK_PERIOD     = 40;
    localparam int DRIVE_DELAY    = 2;
    localparam int RESET_CYCLES   = 16;
    localparam int RAM_BITS       = 11;
    localparam int TIMER_BITS     = 6;
    localparam int PIN_PORTS      = 2;
    localparam int RAM_WORDS      = 8;
    localparam int IRQ_WAIT_LIMIT = 2 ** TIMER_BITS + 8;
    // idle window after reset that ends just before the first timer wrap
    localparam int QUIET_CYCLES   = 2 ** TIMER_BITS - 4;

    // region number sits in paddr[31:27]
    localparam logic [31:0] RAM_BASE   = 32'h1000_0000;
    localparam logic [31:0] NONE_BASE  = 32'h2800_0000;
    localparam logic [31:0] TIMER_BASE = 32'hF000_0000;
    localparam logic [31:0] PORT_BASE  = 32'hF800_0000;

    // levels applied to the pin inputs, port 1 in the upper bit
    localparam logic [1:0] SCL_LEVELS = 2'b01;
    localparam logic [1:0] SDA_LEVELS = 2'b10;

    typedef enum {OP_WRITE, OP_READ, OP_PINS, OP_IRQ, OP_QUIET, OP_WAIT_IRQ} op_e;

    typedef struct {
        op_e         op;
        int          group;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  strb;
        logic [31:0] exp_data;
        logic        exp_err;
    } row_t;

    logic                 clk;
    logic                 reset;
    logic                 psel;
    logic                 penable;
    logic [31:0]          paddr;
    logic                 pwrite;
    logic [31:0]          pwdata;
    logic [3:0]           pstrb;
    logic [31:0]          prdata;
    logic                 pready;
    logic                 pslverr;
    logic [PIN_PORTS-1:0] scl_in;
    logic [PIN_PORTS-1:0] sda_in;
    logic [PIN_PORTS-1:0] scl_drive;
    logic [PIN_PORTS-1:0] sda_drive;
    logic                 irq;

    row_t        rows[$];
    logic [31:0] ram_model [2 ** RAM_BITS];
    logic [15:0] lfsr;
    logic        row_failed;
    int          passed;
    int          failed;
    int          check_errors;

    periph_top #(
        .RAM_BITS   (RAM_BITS),
        .TIMER_BITS (TIMER_BITS),
        .PIN_PORTS  (PIN_PORTS)
    ) u_dut (
        .clk       (clk),
        .reset     (reset),
        .psel      (psel),
        .penable   (penable),
        .paddr     (paddr),
        .pwrite    (pwrite),
        .pwdata    (pwdata),
        .pstrb     (pstrb),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .scl_in    (scl_in),
        .sda_in    (sda_in),
        .scl_drive (scl_drive),
        .sda_drive (sda_drive),
        .irq       (irq)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic random_word(output logic [31:0] w);
        w = '0;
        for (int b = 0; b < 32; b++) begin
            lfsr = lfsr_next(lfsr);
            w = {w[30:0], lfsr[15]};
        end
    endtask

    function automatic logic [31:0] merge_lanes(input logic [31:0] old_word,
                                                input logic [31:0] new_word,
                                                input logic [3:0]  strb);
        logic [31:0] mask;
        mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
        return (old_word & ~mask) | (new_word & mask);
    endfunction

    function automatic logic [RAM_BITS-1:0] word_at(input int i);
        return RAM_BITS'((i * 291 + 5) % (2 ** RAM_BITS));
    endfunction

    function automatic logic [31:0] word_addr(input logic [31:0] base, input int i);
        return base | {19'b0, word_at(i), 2'b00};
    endfunction

    // read word is {scl_in, sda_in, scl_drive, sda_drive}
    function automatic logic [31:0] port_expect(input logic port, input logic scl_d,
                                                input logic sda_d);
        return {28'b0, SCL_LEVELS[port], SDA_LEVELS[port], scl_d, sda_d};
    endfunction

    task automatic add_row(input op_e op, input int group, input logic [31:0] addr,
                           input logic [31:0] wdata, input logic [3:0] strb,
                           input logic [31:0] exp_data, input logic exp_err);
        row_t r;
        r = '{op, group, addr, wdata, strb, exp_data, exp_err};
        rows.push_back(r);
    endtask

    task automatic masked_write(input int i, input logic [3:0] strb);
        logic [31:0] data;
        random_word(data);
        ram_model[word_at(i)] = merge_lanes(ram_model[word_at(i)], data, strb);
        add_row(OP_WRITE, 3, word_addr(RAM_BASE, i), data, strb, 32'h0, 1'b0);
    endtask

    task automatic build_rows();
        logic [31:0] data;
        add_row(OP_PINS, 1, 32'h0, 32'h0, 4'h0, 32'h0, 1'b0);
        add_row(OP_IRQ, 1, 32'h0, 32'h0, 4'h0, 32'h0, 1'b0);
        // wdata holds the number of idle cycles
        add_row(OP_QUIET, 1, 32'h0, QUIET_CYCLES, 4'h0, 32'h0, 1'b0);
        for (int i = 0; i < RAM_WORDS; i++) begin
            random_word(data);
            ram_model[word_at(i)] = data;
            add_row(OP_WRITE, 2, word_addr(RAM_BASE, i), data, 4'hf, 32'h0, 1'b0);
        end
        for (int i = 0; i < RAM_WORDS; i++) begin
            add_row(OP_READ, 2, word_addr(RAM_BASE, i), 32'h0, 4'h0, ram_model[word_at(i)], 1'b0);
        end
        masked_write(0, 4'b0001);
        masked_write(1, 4'b0110);
        masked_write(2, 4'b1000);
        for (int i = 0; i < 3; i++) begin
            add_row(OP_READ, 3, word_addr(RAM_BASE, i), 32'h0, 4'h0, ram_model[word_at(i)], 1'b0);
        end
        add_row(OP_READ, 4, PORT_BASE, 32'h0, 4'h0, port_expect(1'b0, 1'b0, 1'b0), 1'b0);
        add_row(OP_WRITE, 4, PORT_BASE + 32'h4, 32'h2, 4'h1, 32'h0, 1'b0);
        add_row(OP_PINS, 4, 32'h0, 32'h0, 4'h0, 32'h8, 1'b0);
        add_row(OP_READ, 4, PORT_BASE + 32'h4, 32'h0, 4'h0, port_expect(1'b1, 1'b1, 1'b0), 1'b0);
        add_row(OP_READ, 4, PORT_BASE, 32'h0, 4'h0, port_expect(1'b0, 1'b0, 1'b0), 1'b0);
        // unmapped region 5 aliases RAM word 0 in its low bits
        add_row(OP_WRITE, 5, word_addr(NONE_BASE, 0), ~ram_model[word_at(0)], 4'hf, 32'h0, 1'b1);
        add_row(OP_READ, 5, word_addr(NONE_BASE, 0), 32'h0, 4'h0, 32'h0, 1'b1);
        add_row(OP_READ, 5, word_addr(RAM_BASE, 0), 32'h0, 4'h0, ram_model[word_at(0)], 1'b0);
        add_row(OP_WRITE, 5, PORT_BASE + 32'h8, 32'h3, 4'h1, 32'h0, 1'b1);
        add_row(OP_READ, 5, PORT_BASE + 32'h8, 32'h0, 4'h0, 32'h0, 1'b1);
        add_row(OP_PINS, 5, 32'h0, 32'h0, 4'h0, 32'h8, 1'b0);
        add_row(OP_WAIT_IRQ, 6, 32'h0, 32'h0, 4'h0, 32'h0, 1'b0);
        add_row(OP_READ, 6, TIMER_BASE, 32'h0, 4'h0, 32'h1, 1'b0);
        add_row(OP_IRQ, 6, 32'h0, 32'h0, 4'h0, 32'h1, 1'b0);
        // clear bit is wdata[8] in lane 1
        add_row(OP_WRITE, 6, TIMER_BASE, 32'h100, 4'b0010, 32'h0, 1'b0);
        add_row(OP_READ, 6, TIMER_BASE, 32'h0, 4'h0, 32'h0, 1'b0);
        add_row(OP_IRQ, 6, 32'h0, 32'h0, 4'h0, 32'h0, 1'b0);
    endtask

    task automatic apb_transfer(input logic wr, input logic [31:0] addr,
                                input logic [31:0] data, input logic [3:0] strb,
                                output logic [31:0] rdata, output logic ready,
                                output logic err);
        @(posedge clk);
        #DRIVE_DELAY;
        psel    = 1'b1;
        penable = 1'b0;
        paddr   = addr;
        pwrite  = wr;
        pwdata  = data;
        pstrb   = strb;
        @(posedge clk);
        #DRIVE_DELAY;
        penable = 1'b1;
        // mid access cycle
        @(negedge clk);
        rdata = prdata;
        ready = pready;
        err   = pslverr;
    endtask

    task automatic bus_idle();
        @(posedge clk);
        #DRIVE_DELAY;
        psel    = 1'b0;
        penable = 1'b0;
        @(negedge clk);
    endtask

    task automatic check_value(input int idx, input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        assert (got === expected) else begin
            $display("** Error at %0t: row %0d %s is 0x%h, expected 0x%h",
                     $time, idx, what, got, expected);
            check_errors++;
            row_failed = 1'b1;
        end
    endtask

    task automatic run_row(input int idx);
        row_t        r;
        logic [31:0] rdata;
        logic        ready;
        logic        err;
        int          waited;
        r          = rows[idx];
        row_failed = 1'b0;
        waited     = 0;
        case (r.op)
            OP_WRITE, OP_READ: begin
                apb_transfer(r.op == OP_WRITE, r.addr, r.wdata, r.strb, rdata, ready, err);
                check_value(idx, "pready", 32'(ready), 32'd1);
                check_value(idx, "pslverr", 32'(err), 32'(r.exp_err));
                if (r.op == OP_READ || r.exp_err) begin
                    check_value(idx, "prdata", rdata, r.exp_data);
                end
            end
            OP_PINS: begin
                bus_idle();
                check_value(idx, "drive pins", {28'b0, scl_drive, sda_drive}, r.exp_data);
            end
            OP_IRQ: begin
                bus_idle();
                check_value(idx, "irq", {31'b0, irq}, r.exp_data);
            end
            OP_QUIET: begin
                for (int c = 0; c < int'(r.wdata) && !row_failed; c++) begin
                    bus_idle();
                    check_value(idx, "irq and drive pins",
                                {27'b0, irq, scl_drive, sda_drive}, r.exp_data);
                end
            end
            default: begin
                bus_idle();
                while (irq !== 1'b1 && waited < IRQ_WAIT_LIMIT) begin
                    @(negedge clk);
                    waited++;
                end
                assert (irq === 1'b1) else begin
                    $display("row %0d: the timer interrupt did not rise within %0d cycles",
                             idx, IRQ_WAIT_LIMIT);
                    check_errors++;
                    row_failed = 1'b1;
                end
            end
        endcase
        if (row_failed) begin
            failed++;
            $display("test %0d (%s, behavior %0d) failed", idx, r.op.name(), r.group);
        end else begin
            passed++;
            $display("test %0d (%s, behavior %0d) passed", idx, r.op.name(), r.group);
        end
    endtask

    initial begin
        reset        = 1'b0;
        psel         = 1'b0;
        penable      = 1'b0;
        paddr        = '0;
        pwrite       = 1'b0;
        pwdata       = '0;
        pstrb        = '0;
        scl_in       = SCL_LEVELS;
        sda_in       = SDA_LEVELS;
        lfsr         = 16'd54;
        passed       = 0;
        failed       = 0;
        check_errors = 0;
        build_rows();
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        reset = 1'b1;
        foreach (rows[i]) begin
            run_row(i);
        end
        bus_idle();
        $display("%0d tests, %0d passed, %0d failed, %0d check errors",
                 rows.size(), passed, failed, check_errors);
        if (failed == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    // two cycles per transfer, the quiet window, and room for the timer wait
    initial begin
        #1;
        repeat (RESET_CYCLES + QUIET_CYCLES + rows.size() * 2 + 200) @(posedge clk);
        $display("watchdog expired, the run did not finish in time");
        $display("Test failures found");
        $finish;
    end

endmodule

// ==== run.sh ====
#!/bin/sh
# compile with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module periph_tb -f sim.f -o periph_sim \
    && ./obj_dir/periph_sim | tee /dev/stderr | grep -F "All tests passed!" > /dev/null \
    && exit 0 \
    || exit 1

// ==== sim.f ====
src/periph_pkg.sv
src/apb_region_decoder.sv
src/word_ram.sv
src/pin_port.sv
src/tick_timer.sv
src/read_return.sv
src/periph_top.sv
bench/periph_assert.sv
bench/periph_tb.sv

// ==== src/apb_region_decoder.sv ====
`timescale 1ns/100ps

module apb_region_decoder import periph_pkg::*; #(
    parameter int PIN_PORTS = 2
) (
    input  logic     clk,
    input  logic     reset,
    input  apb_req_t req,
    input  logic     psel,
    input  logic     penable,
    output decode_t  dec
);

    apb_req_t                   req_q;
    apb_req_t                   src;
    logic                       setup;
    logic                       access;
    logic                       write_q;
    region_e                    region;
    logic [PORT_INDEX_BITS-1:0] port_index;

    // address map, anything not listed is unmapped
    function automatic region_e classify(input logic [31:0] addr);
        region_e r;
        case (addr[31:REGION_START_BIT])
            REGION_RAM:   r = REGION_RAM;
            REGION_TIMER: r = REGION_TIMER;
            REGION_PORTS: r = REGION_PORTS;
            default:      r = REGION_NONE;
        endcase
        return r;
    endfunction

    assign setup  = psel && !penable;
    assign access = psel && penable;

    // setup decodes the live request so targets can capture read words
    // at the setup edge; access uses the copy taken at that edge
    assign src        = setup ? req : req_q;
    assign port_index = src.paddr[WORD_INDEX_LSB +: PORT_INDEX_BITS];

    always_comb begin
        region = classify(src.paddr);
        // a port beyond the bank is treated like an unmapped region
        if (region == REGION_PORTS && int'(port_index) >= PIN_PORTS) begin
            region = REGION_NONE;
        end
    end

    always_ff @(posedge clk) begin
        if (setup) begin
            req_q <= req;
        end
    end

    // writes to unmapped space never reach a target
    always_ff @(posedge clk) begin
        if (!reset) begin
            write_q <= 1'b0;
        end else begin
            write_q <= setup && req.pwrite && (region != REGION_NONE);
        end
    end

    always_comb begin
        dec.region     = region;
        dec.word_index = src.paddr[WORD_INDEX_LSB +: WORD_INDEX_BITS];
        dec.port_index = port_index;
        dec.write      = write_q && access;
        dec.strb       = src.pstrb;
        dec.wdata      = src.pwdata;
        dec.read       = setup;
    end

endmodule

// ==== src/periph_pkg.sv ====
package periph_pkg;

    // region select lives in the top address bits
    localparam int REGION_START_BIT = 27;
    localparam int REGION_BITS      = 32 - REGION_START_BIT;

    // word and port fields below the region bits
    localparam int WORD_INDEX_LSB  = 2;
    localparam int WORD_INDEX_BITS = 14;
    localparam int PORT_INDEX_BITS = 4;

    // payload bits of a port read word
    localparam int PORT_DATA_BITS = 4;

    typedef enum logic [REGION_BITS-1:0] {
        REGION_NONE  = 5'd0,
        REGION_RAM   = 5'd2,
        REGION_TIMER = 5'd30,
        REGION_PORTS = 5'd31
    } region_e;

    // APB request fields as seen at the completer port
    typedef struct packed {
        logic [31:0] paddr;
        logic        pwrite;
        logic [31:0] pwdata;
        logic [3:0]  pstrb;
    } apb_req_t;

    // one decoded transfer, shared by every target
    typedef struct packed {
        region_e                    region;
        logic [WORD_INDEX_BITS-1:0] word_index;
        logic [PORT_INDEX_BITS-1:0] port_index;
        // write commits at the end of this cycle
        logic                       write;
        logic [3:0]                 strb;
        logic [31:0]                wdata;
        // read word is captured at the end of this cycle
        logic                       read;
    } decode_t;

endpackage

// ==== src/periph_top.sv ====
`timescale 1ns/100ps

module periph_top import periph_pkg::*; #(
    parameter int RAM_BITS   = 11,
    parameter int TIMER_BITS = 22,
    parameter int PIN_PORTS  = 2
) (
    input  logic                 clk,
    input  logic                 reset,

    // APB completer
    input  logic                 psel,
    input  logic                 penable,
    input  logic [31:0]          paddr,
    input  logic                 pwrite,
    input  logic [31:0]          pwdata,
    input  logic [3:0]           pstrb,
    output logic [31:0]          prdata,
    output logic                 pready,
    output logic                 pslverr,

    // open-drain pin pairs
    input  logic [PIN_PORTS-1:0] scl_in,
    input  logic [PIN_PORTS-1:0] sda_in,
    output logic [PIN_PORTS-1:0] scl_drive,
    output logic [PIN_PORTS-1:0] sda_drive,

    output logic                 irq
);

    apb_req_t                   req;
    decode_t                    dec;
    logic [31:0]                ram_rdata;
    logic [31:0]                timer_rdata;
    logic [PIN_PORTS-1:0][31:0] port_rdata;

    assign req = '{paddr: paddr, pwrite: pwrite, pwdata: pwdata, pstrb: pstrb};

    apb_region_decoder #(
        .PIN_PORTS (PIN_PORTS)
    ) u_decoder (
        .clk     (clk),
        .reset   (reset),
        .req     (req),
        .psel    (psel),
        .penable (penable),
        .dec     (dec)
    );

    word_ram #(
        .RAM_BITS (RAM_BITS)
    ) u_ram (
        .clk   (clk),
        .dec   (dec),
        .rdata (ram_rdata)
    );

    tick_timer #(
        .TIMER_BITS (TIMER_BITS)
    ) u_timer (
        .clk   (clk),
        .reset (reset),
        .dec   (dec),
        .irq   (irq),
        .rdata (timer_rdata)
    );

    for (genvar i = 0; i < PIN_PORTS; i++) begin : g_port
        pin_port #(
            .PORT_ID (i)
        ) u_port (
            .clk       (clk),
            .reset     (reset),
            .dec       (dec),
            .scl_in    (scl_in[i]),
            .sda_in    (sda_in[i]),
            .scl_drive (scl_drive[i]),
            .sda_drive (sda_drive[i]),
            .rdata     (port_rdata[i])
        );
    end

    read_return #(
        .PIN_PORTS (PIN_PORTS)
    ) u_return (
        .clk         (clk),
        .reset       (reset),
        .dec         (dec),
        .ram_rdata   (ram_rdata),
        .timer_rdata (timer_rdata),
        .port_rdata  (port_rdata),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr)
    );

endmodule

// ==== src/pin_port.sv ====
`timescale 1ns/100ps

module pin_port import periph_pkg::*; #(
    parameter int PORT_ID = 0
) (
    input  logic        clk,
    input  logic        reset,
    input  decode_t     dec,
    input  logic        scl_in,
    input  logic        sda_in,
    output logic        scl_drive,
    output logic        sda_drive,
    output logic [31:0] rdata
);

    logic [1:0]                scl_sync;
    logic [1:0]                sda_sync;
    logic [PORT_DATA_BITS-1:0] port_word;
    logic                      selected;

    assign selected = (dec.region == REGION_PORTS)
                   && (dec.port_index == PORT_INDEX_BITS'(PORT_ID));

    // pins are asynchronous to clk
    always_ff @(posedge clk) begin
        scl_sync <= {scl_sync[0], scl_in};
        sda_sync <= {sda_sync[0], sda_in};
    end

    // a set drive bit pulls the line low, cleared means released
    always_ff @(posedge clk) begin
        if (!reset) begin
            scl_drive <= 1'b0;
            sda_drive <= 1'b0;
        end else if (selected && dec.write && dec.strb[0]) begin
            scl_drive <= dec.wdata[1];
            sda_drive <= dec.wdata[0];
        end
    end

    always_ff @(posedge clk) begin
        if (selected && dec.read) begin
            port_word <= {scl_sync[1], sda_sync[1], scl_drive, sda_drive};
        end
    end

    assign rdata = {{(32 - PORT_DATA_BITS){1'b0}}, port_word};

endmodule

// ==== src/read_return.sv ====
`timescale 1ns/100ps

module read_return import periph_pkg::*; #(
    parameter int PIN_PORTS = 2
) (
    input  logic                      clk,
    input  logic                      reset,
    input  decode_t                   dec,
    input  logic [31:0]               ram_rdata,
    input  logic [31:0]               timer_rdata,
    input  logic [PIN_PORTS-1:0][31:0] port_rdata,
    output logic [31:0]               prdata,
    output logic                      pready,
    output logic                      pslverr
);

    region_e                    region_q;
    logic [PORT_INDEX_BITS-1:0] port_q;
    logic [31:0]                port_word;

    // completion is fixed one cycle after setup
    always_ff @(posedge clk) begin
        if (!reset) begin
            pready   <= 1'b0;
            pslverr  <= 1'b0;
            region_q <= REGION_NONE;
        end else begin
            pready  <= dec.read;
            pslverr <= dec.read && (dec.region == REGION_NONE);
            if (dec.read) begin
                region_q <= dec.region;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (dec.read) begin
            port_q <= dec.port_index;
        end
    end

    // decoder already folded bad port numbers into REGION_NONE
    always_comb begin
        port_word = '0;
        for (int i = 0; i < PIN_PORTS; i++) begin
            if (port_q == PORT_INDEX_BITS'(i)) begin
                port_word = port_rdata[i];
            end
        end
    end

    // unmapped returns zero
    always_comb begin
        case (region_q)
            REGION_RAM:   prdata = ram_rdata;
            REGION_TIMER: prdata = timer_rdata;
            REGION_PORTS: prdata = port_word;
            default:      prdata = '0;
        endcase
    end

endmodule

// ==== src/tick_timer.sv ====
`timescale 1ns/100ps

module tick_timer import periph_pkg::*; #(
    parameter int TIMER_BITS = 22
) (
    input  logic        clk,
    input  logic        reset,
    input  decode_t     dec,
    output logic        irq,
    output logic [31:0] rdata
);

    logic [TIMER_BITS-1:0] count;
    logic                  irq_word;
    logic                  selected;
    logic                  clear;

    assign selected = (dec.region == REGION_TIMER);

    // clear sits in lane 1, bit 8
    assign clear = selected && dec.write && dec.strb[1] && dec.wdata[8];

    always_ff @(posedge clk) begin
        if (!reset) begin
            count <= '0;
        end else begin
            count <= count + TIMER_BITS'(1);
        end
    end

    // sticky flag, a wrap in the same cycle beats the clear
    always_ff @(posedge clk) begin
        if (!reset) begin
            irq <= 1'b0;
        end else if (&count) begin
            irq <= 1'b1;
        end else if (clear) begin
            irq <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (selected && dec.read) begin
            irq_word <= irq;
        end
    end

    assign rdata = {31'b0, irq_word};

endmodule

// ==== src/word_ram.sv ====
`timescale 1ns/100ps

module word_ram import periph_pkg::*; #(
    parameter int RAM_BITS = 11
) (
    input  logic        clk,
    input  decode_t     dec,
    output logic [31:0] rdata
);

    localparam int WORDS = 2 ** RAM_BITS;
    localparam int LANES = 4;

    // four byte lanes per word
    logic [LANES-1:0][7:0] mem [WORDS];
    logic [RAM_BITS-1:0]   addr;
    logic                  selected;

    assign addr     = dec.word_index[RAM_BITS-1:0];
    assign selected = (dec.region == REGION_RAM);

    // only strobed lanes change
    always_ff @(posedge clk) begin
        if (selected && dec.write) begin
            for (int lane = 0; lane < LANES; lane++) begin
                if (dec.strb[lane]) begin
                    mem[addr][lane] <= dec.wdata[8*lane +: 8];
                end
            end
        end
    end

    // whole word registered for the access cycle
    always_ff @(posedge clk) begin
        if (selected && dec.read) begin
            rdata <= mem[addr];
        end
    end

endmodule
